//--- tb/clint_golden.txt
# W addr data | R addr expected | M addr min max | I msip mtip | D cycles
# All fields hexadecimal, addr is the bus word address
I 0 0
R 00 00000000
R 03 FFFFFFFF
R 07 FFFFFFFF
W 00 FFFFFFFF
R 00 00000001
I 1 0
W 00 00000000
I 0 0
W 02 00000100
W 06 00000000
D 64
M 02 00000109 0000010C
W 02 FFFFFFF0
D 12C
R 06 00000001
W 02 00001000
W 06 00000000
W 03 00001005
W 07 00000000
I 0 0
M 02 00001000 00001002
D 50
I 0 1
W 07 FFFFFFFF
I 0 0
W 40 40BF5A00
W 41 41BE5A11
W 42 42BD5A22
W 43 43BC5A33
W 44 44BB5A44
W 45 45BA5A55
W 46 46B95A66
W 47 47B85A77
W 48 48B75A88
W 49 49B65A99
W 4A 4AB55AAA
W 4B 4BB45ABB
W 4C 4CB35ACC
W 4D 4DB25ADD
W 4E 4EB15AEE
W 4F 4FB05AFF
R 40 40BF5A00
R 41 41BE5A11
R 42 42BD5A22
R 43 43BC5A33
R 44 44BB5A44
R 45 45BA5A55
R 46 46B95A66
R 47 47B85A77
R 48 48B75A88
R 49 49B65A99
R 4A 4AB55AAA
R 4B 4BB45ABB
R 4C 4CB35ACC
R 4D 4DB25ADD
R 4E 4EB15AEE
R 4F 4FB05AFF
R 03 00001005
R 01 00000000
R 04 00000000
R 05 00000000
R 80 00000000
R C0 00000000
W 01 AAAAAAAA
W 04 55555555
W 05 CAFEF00D
W 80 DEADBEEF
W C3 12345678
R 00 00000000
R 03 00001005
R 07 FFFFFFFF
R 40 40BF5A00
R 43 43BC5A33
I 0 0

//--- sim.f
rtl/clint_pkg.sv
rtl/wb_map_pkg.sv
rtl/clint_timer.sv
rtl/clint_regs.sv
rtl/scratch_ram.sv
rtl/wb_decoder.sv
rtl/clint_subsys.sv
tb/tb_clint_subsys.sv

//--- Makefile
# Verilator build and run of the CLINT subsystem testbench

BIN := obj_dir/Vtb_clint_subsys

.PHONY: all run clean

all: run

$(BIN): sim.f $(wildcard rtl/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing -Wno-fatal --top-module tb_clint_subsys -f sim.f

run: $(BIN)
	$(BIN) | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- tb/tb_clint_subsys.sv
`timescale 1ns/1ps

module tb_clint_subsys
  import clint_pkg::*;
  import wb_map_pkg::*;
();

  localparam int    ACK_LIMIT    = 8;
  localparam int    LINE_CYCLES  = 20;
  localparam int    RESET_CYCLES = 4;
  localparam string GOLDEN_FILE  = "tb/clint_golden.txt";

  logic              CLK_I = 1'b0;
  logic              RST_I;
  logic              cyc;
  logic              stb;
  logic              we;
  logic [ADR_W-1:0]  adr;
  logic [DATA_W-1:0] dat_w;
  logic [DATA_W-1:0] dat_r;
  logic              ack;
  logic              msip_irq;
  logic              mtip;
  logic [TIME_W-1:0] mtime;

  // Operations as read from the golden file
  byte         op_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];
  logic [31:0] c_q[$];

  int mismatches;
  int other_errors;
  int cycle_limit;
  int cycles;

  clint_subsys clint_subsys_i (
    .CLK_I    (CLK_I),
    .RST_I    (RST_I),
    .cyc      (cyc),
    .stb      (stb),
    .we       (we),
    .adr      (adr),
    .dat_w    (dat_w),
    .dat_r    (dat_r),
    .ack      (ack),
    .msip_irq (msip_irq),
    .mtip     (mtip),
    .mtime    (mtime)
  );

  always #20 CLK_I = ~CLK_I;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("ERROR %s expected %08h actual %08h", name, exp, act);
      mismatches++;
    end
  endtask

  // Closest bound when out of range, the value itself otherwise
  function automatic logic [31:0] nearest_in_range(input logic [31:0] v,
                                                   input logic [31:0] lo,
                                                   input logic [31:0] hi);
    return (v < lo) ? lo : ((v > hi) ? hi : v);
  endfunction

  task automatic store_op(input byte op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c, input bit complete);
    if (!complete) begin
      $display("golden file line for '%c' has missing fields", op);
      other_errors++;
    end
    op_q.push_back(op);
    a_q.push_back(a);
    b_q.push_back(b);
    c_q.push_back(c);
    cycle_limit += LINE_CYCLES;
  endtask

  // Also sums up the cycle budget for the watchdog
  task automatic load_golden();
    int               fd;
    int               n;
    byte              op;
    logic [31:0]      a;
    logic [31:0]      b;
    logic [31:0]      c;
    logic [8*128-1:0] rest;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("cannot open golden file %s", GOLDEN_FILE);
      other_errors++;
      return;
    end
    cycle_limit = RESET_CYCLES + LINE_CYCLES;
    while (!$feof(fd)) begin
      n = $fscanf(fd, " %c", op);
      if (n != 1) begin
        break;
      end
      a = '0;
      b = '0;
      c = '0;
      case (op)
        "#": n = $fgets(rest, fd);
        "W", "R", "I": begin
          n = $fscanf(fd, "%h %h", a, b);
          store_op(op, a, b, c, n == 2);
        end
        "M": begin
          n = $fscanf(fd, "%h %h %h", a, b, c);
          store_op(op, a, b, c, n == 3);
        end
        "D": begin
          n = $fscanf(fd, "%h", a);
          store_op(op, a, b, c, n == 1);
          cycle_limit += int'(a);
        end
        default: begin
          $display("unknown operation '%c' in golden file", op);
          other_errors++;
          n = $fgets(rest, fd);
        end
      endcase
    end
    $fclose(fd);
  endtask

  // One Wishbone classic cycle, stb dropped again after ack
  task automatic bus_cycle(input logic write, input logic [ADR_W-1:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic acked);
    int waited;
    waited = 0;
    acked  = 1'b0;
    rdata  = '0;
    @(posedge CLK_I);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= write;
    adr   <= addr;
    dat_w <= wdata;
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge CLK_I);
      if (ack) begin
        acked = 1'b1;
        rdata = dat_r;
      end else begin
        waited++;
      end
    end
    if (!acked) begin
      $display("no acknowledge from address %02h within %0d cycles", addr, ACK_LIMIT);
      other_errors++;
    end
    @(posedge CLK_I);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic run_op(input int idx);
    byte         op;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] rdata;
    logic [31:0] mtime_half;
    logic        acked;
    string       name;
    op   = op_q[idx];
    a    = a_q[idx];
    b    = b_q[idx];
    c    = c_q[idx];
    name = $sformatf("op %0d %c %02h", idx + 1, op, a[7:0]);
    case (op)
      "W": bus_cycle(1'b1, a[ADR_W-1:0], b, rdata, acked);
      "R": begin
        bus_cycle(1'b0, a[ADR_W-1:0], '0, rdata, acked);
        if (acked) check(name, b, rdata);
      end
      "M": begin
        bus_cycle(1'b0, a[ADR_W-1:0], '0, rdata, acked);
        if (acked) check(name, nearest_in_range(rdata, b, c), rdata);
        // Exported mtime half within the same window
        @(negedge CLK_I);
        mtime_half = a[2] ? mtime[TIME_W-1:DATA_W] : mtime[DATA_W-1:0];
        check({name, " mtime port"}, nearest_in_range(mtime_half, b, c), mtime_half);
      end
      "I": begin
        @(negedge CLK_I);
        check({name, " msip_irq"}, a, {31'b0, msip_irq});
        check({name, " mtip"}, b, {31'b0, mtip});
      end
      default: repeat (int'(a)) @(posedge CLK_I);
    endcase
  endtask

  initial begin : watchdog
    cycles = 0;
    wait (cycle_limit > 0);
    while (cycles < cycle_limit) begin
      @(posedge CLK_I);
      cycles++;
    end
    $display("timeout, run did not end within %0d cycles", cycle_limit);
    $display("sim failed");
    $finish;
  end

  initial begin
    RST_I        = 1'b1;
    cyc          = 1'b0;
    stb          = 1'b0;
    we           = 1'b0;
    adr          = '0;
    dat_w        = '0;
    mismatches   = 0;
    other_errors = 0;
    cycle_limit  = 0;
    load_golden();
    repeat (RESET_CYCLES) @(posedge CLK_I);
    RST_I <= 1'b0;
    if (other_errors == 0) begin
      for (int i = 0; i < op_q.size(); i++) begin
        run_op(i);
      end
    end
    $display("mismatches %0d, other failures %0d", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- rtl/clint_subsys.sv
`timescale 1ns/1ps

module clint_subsys
  import clint_pkg::*;
  import wb_map_pkg::*;
(
  input  logic              CLK_I,
  input  logic              RST_I,
  input  logic              cyc,
  input  logic              stb,
  input  logic              we,
  input  logic [ADR_W-1:0]  adr,
  input  logic [DATA_W-1:0] dat_w,
  output logic [DATA_W-1:0] dat_r,
  output logic              ack,
  output logic              msip_irq,
  output logic              mtip,
  output logic [TIME_W-1:0] mtime
);

  logic              clint_stb;
  logic [DATA_W-1:0] clint_dat_r;
  logic              clint_ack;
  logic              ram_stb;
  logic [DATA_W-1:0] ram_dat_r;
  logic              ram_ack;

  wb_decoder decoder_i (
    .CLK_I       (CLK_I),
    .RST_I       (RST_I),
    .stb         (stb),
    .adr         (adr),
    .clint_stb   (clint_stb),
    .ram_stb     (ram_stb),
    .clint_dat_r (clint_dat_r),
    .clint_ack   (clint_ack),
    .ram_dat_r   (ram_dat_r),
    .ram_ack     (ram_ack),
    .dat_r       (dat_r),
    .ack         (ack),
    .cyc         (cyc)
  );

  // Timer block sees the low 3 address bits as word offset
  clint_regs regs_i (
    .CLK_I    (CLK_I),
    .RST_I    (RST_I),
    .cyc      (cyc),
    .stb      (clint_stb),
    .we       (we),
    .adr      (adr[REG_ADR_W-1:0]),
    .dat_w    (dat_w),
    .dat_r    (clint_dat_r),
    .ack      (clint_ack),
    .msip_irq (msip_irq),
    .mtip     (mtip),
    .mtime    (mtime)
  );

  scratch_ram ram_i (
    .CLK_I (CLK_I),
    .RST_I (RST_I),
    .cyc   (cyc),
    .stb   (ram_stb),
    .we    (we),
    .adr   (adr[RAM_ADR_W-1:0]),
    .dat_w (dat_w),
    .dat_r (ram_dat_r),
    .ack   (ram_ack)
  );

endmodule

//--- rtl/wb_decoder.sv
`timescale 1ns/1ps

module wb_decoder
  import clint_pkg::*;
  import wb_map_pkg::*;
(
  input  logic              CLK_I,
  input  logic              RST_I,
  input  logic              stb,
  input  logic [ADR_W-1:0]  adr,
  output logic              clint_stb,
  output logic              ram_stb,
  input  logic [DATA_W-1:0] clint_dat_r,
  input  logic              clint_ack,
  input  logic [DATA_W-1:0] ram_dat_r,
  input  logic              ram_ack,
  output logic [DATA_W-1:0] dat_r,
  output logic              ack,
  input  logic              cyc
);

  logic [SEL_W-1:0] region;
  slave_sel_e       sel;
  logic             none_ack;

  assign region = adr[ADR_W-1:SEL_LSB];

  always_comb begin
    case (region)
      2'b00:   sel = SEL_CLINT;
      2'b01:   sel = SEL_RAM;
      default: sel = SEL_NONE;
    endcase
  end

  // Strobe reaches the selected slave only
  assign clint_stb = stb & (sel == SEL_CLINT);
  assign ram_stb   = stb & (sel == SEL_RAM);

  // Own response for holes in the map, same pulse as the slaves
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      none_ack <= 1'b0;
    end else begin
      none_ack <= cyc & stb & (sel == SEL_NONE) & ~none_ack;
    end
  end

  // Return path
  always_comb begin
    case (sel)
      SEL_CLINT: begin
        dat_r = clint_dat_r;
        ack   = clint_ack;
      end
      SEL_RAM: begin
        dat_r = ram_dat_r;
        ack   = ram_ack;
      end
      default: begin
        dat_r = '0;
        ack   = none_ack;
      end
    endcase
  end

endmodule

//--- rtl/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram
  import clint_pkg::*;
  import wb_map_pkg::*;
(
  input  logic                 CLK_I,
  input  logic                 RST_I,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [RAM_ADR_W-1:0] adr,
  input  logic [DATA_W-1:0]    dat_w,
  output logic [DATA_W-1:0]    dat_r,
  output logic                 ack
);

  logic [DATA_W-1:0] mem [2**RAM_ADR_W];
  logic              access;

  assign access = cyc & stb & ~ack;

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  // Write lands on the edge that raises ack
  always_ff @(posedge CLK_I) begin
    if (access && we) begin
      mem[adr] <= dat_w;
    end
  end

  // Read word comes out together with ack
  always_ff @(posedge CLK_I) begin
    if (access && !we) begin
      dat_r <= mem[adr];
    end
  end

endmodule

//--- rtl/clint_regs.sv
`timescale 1ns/1ps

module clint_regs
  import clint_pkg::*;
(
  input  logic                 CLK_I,
  input  logic                 RST_I,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [REG_ADR_W-1:0] adr,
  input  logic [DATA_W-1:0]    dat_w,
  output logic [DATA_W-1:0]    dat_r,
  output logic                 ack,
  output logic                 msip_irq,
  output logic                 mtip,
  output logic [TIME_W-1:0]    mtime
);

  clint_reg_e        reg_off;
  logic              access;
  logic              wr_en;
  logic              msip_q;
  logic [TIME_W-1:0] mtimecmp;
  logic              load_lo;
  logic              load_hi;

  assign reg_off = clint_reg_e'(adr);

  // Only the first sampled edge of a bus cycle counts
  assign access = cyc & stb & ~ack;
  assign wr_en  = access & we;

  // Single-cycle acknowledge
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  // Software interrupt, bit 0 only
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      msip_q <= 1'b0;
    end else if (wr_en && (reg_off == REG_MSIP)) begin
      msip_q <= dat_w[0];
    end
  end

  assign msip_irq = msip_q;

  // Compare register, written by halves
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      mtimecmp <= MTIMECMP_RESET;
    end else if (wr_en) begin
      case (reg_off)
        REG_MTIMECMP_LO: mtimecmp[DATA_W-1:0]      <= dat_w;
        REG_MTIMECMP_HI: mtimecmp[TIME_W-1:DATA_W] <= dat_w;
        default: ;
      endcase
    end
  end

  // mtime lives in the timer, writes go there as half loads
  assign load_lo = wr_en & (reg_off == REG_MTIME_LO);
  assign load_hi = wr_en & (reg_off == REG_MTIME_HI);

  clint_timer timer_i (
    .CLK_I     (CLK_I),
    .RST_I     (RST_I),
    .load_lo   (load_lo),
    .load_hi   (load_hi),
    .load_data (dat_w),
    .mtime     (mtime)
  );

  // Read data straight from storage, held address keeps it valid
  always_comb begin
    case (reg_off)
      REG_MSIP:        dat_r = {{(DATA_W - 1){1'b0}}, msip_q};
      REG_MTIME_LO:    dat_r = mtime[DATA_W-1:0];
      REG_MTIME_HI:    dat_r = mtime[TIME_W-1:DATA_W];
      REG_MTIMECMP_LO: dat_r = mtimecmp[DATA_W-1:0];
      REG_MTIMECMP_HI: dat_r = mtimecmp[TIME_W-1:DATA_W];
      default:         dat_r = '0;
    endcase
  end

  // Timer interrupt, one cycle behind the compare
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      mtip <= 1'b0;
    end else begin
      mtip <= (mtime >= mtimecmp);
    end
  end

endmodule

//--- rtl/clint_timer.sv
`timescale 1ns/1ps

module clint_timer
  import clint_pkg::*;
(
  input  logic              CLK_I,
  input  logic              RST_I,
  input  logic              load_lo,
  input  logic              load_hi,
  input  logic [DATA_W-1:0] load_data,
  output logic [TIME_W-1:0] mtime
);

  logic [TICK_W-1:0] presc;
  logic              tick;

  // Wrap of the prescaler
  assign tick = (presc == TICK_W'(TICK_DIVISOR - 1));

  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      presc <= '0;
    end else if (tick) begin
      presc <= '0;
    end else begin
      presc <= presc + 1'b1;
    end
  end

  // A bus load wins over the tick on the same edge
  always_ff @(posedge CLK_I or posedge RST_I) begin
    if (RST_I) begin
      mtime <= '0;
    end else if (load_lo || load_hi) begin
      // Half not addressed keeps its value
      if (load_lo) begin
        mtime[DATA_W-1:0] <= load_data;
      end
      if (load_hi) begin
        mtime[TIME_W-1:DATA_W] <= load_data;
      end
    end else if (tick) begin
      mtime <= mtime + 1'b1;
    end
  end

endmodule

//--- rtl/wb_map_pkg.sv
package wb_map_pkg;

  // Word address of the bus
  localparam int ADR_W = 8;

  // RAM word index width
  localparam int RAM_ADR_W = 4;

  // Top address bits select the slave
  localparam int SEL_W   = 2;
  localparam int SEL_LSB = ADR_W - SEL_W;

  // 00 timer block, 01 RAM, 10 and 11 unmapped
  typedef enum logic [SEL_W-1:0] {
    SEL_CLINT = 2'b00,
    SEL_RAM   = 2'b01,
    SEL_NONE  = 2'b10
  } slave_sel_e;

endpackage

//--- rtl/clint_pkg.sv
package clint_pkg;

  // Bus data and timer widths
  localparam int DATA_W    = 32;
  localparam int TIME_W    = 64;
  localparam int REG_ADR_W = 3;

  // Clock cycles per mtime step
  localparam int TICK_DIVISOR = 10;
  localparam int TICK_W       = $clog2(TICK_DIVISOR);

  // Compare value out of reset, no timer interrupt pending
  localparam logic [TIME_W-1:0] MTIMECMP_RESET = '1;

  // Word offsets of the timer block
  // Bit 2 picks the upper half of the 64-bit registers
  typedef enum logic [REG_ADR_W-1:0] {
    REG_MSIP        = 3'd0,
    REG_MTIME_LO    = 3'd2,
    REG_MTIMECMP_LO = 3'd3,
    REG_MTIME_HI    = 3'd6,
    REG_MTIMECMP_HI = 3'd7
  } clint_reg_e;

endpackage
